/* Makefile */
# Verilator build and run of the fetch unit testbench

obj_dir/Vfetch_tb: fetch_unit.f $(wildcard source/*.sv) tb/fetch_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
		-f fetch_unit.f -o Vfetch_tb

run: obj_dir/Vfetch_tb
	@out="$$(./obj_dir/Vfetch_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* fetch_unit.f */
source/fetch_pkg.sv
source/fetch_issue_ctrl.sv
source/fetch_attr_fifo.sv
source/fetch_response.sv
source/ilocal_mem.sv
source/ibus_master.sv
source/fetch_unit.sv
tb/fetch_tb.sv

/* source/fetch_attr_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Attribute FIFO
// Two-entry in-order buffer of outstanding fetch attributes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_attr_fifo import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  fetch_attr_t data_in,
    input  logic        pop,
    output logic        full,
    output logic        valid,
    output fetch_attr_t data_out
);

    localparam int PTR_W = $clog2(MAX_INFLIGHT);

    fetch_attr_t           entries [MAX_INFLIGHT];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [INFLIGHT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + INFLIGHT_W'(push) - INFLIGHT_W'(pop);
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    assign full     = (count == INFLIGHT_W'(MAX_INFLIGHT));
    assign valid    = (count != '0);
    assign data_out = entries[rd_ptr];

    no_overflow_a: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("Attribute FIFO push while full");
    no_underflow_a: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("Attribute FIFO pop while empty");

endmodule

/* source/fetch_issue_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch issue controller
// PC register with redirect, source decode, consumer credit counter,
// fault stop and the issue decision that drives both fetch sources
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_issue_ctrl import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        credit_return,
    input  logic        drop,
    input  logic        fifo_full,
    input  fetch_rsp_t  lmem_rsp,
    input  fetch_rsp_t  bus_rsp,
    output fetch_req_t  lmem_req,
    output fetch_req_t  bus_req,
    output logic        attr_push,
    output fetch_attr_t attr_in
);

    logic [31:0]         pc;
    logic [CREDIT_W-1:0] credits;
    logic                fault_stop;
    src_id_t             pc_src;
    logic                in_lmem;
    logic                in_bus;
    logic                sources_ready;
    logic                issue;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    assign in_lmem = (pc - LMEM_BASE) < 32'(LMEM_WORDS * 4);
    assign in_bus  = (pc & BUS_MASK) == BUS_BASE;

    always_comb begin
        if (in_lmem) begin
            pc_src = SRC_LMEM;
        end else if (in_bus) begin
            pc_src = SRC_BUS;
        end else begin
            pc_src = SRC_NONE;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue decision
    // Both sources must be idle so that responses return in order
    assign sources_ready = lmem_rsp.ready & bus_rsp.ready;
    assign issue = (credits != '0) & ~fifo_full & sources_ready & ~fault_stop & ~redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (redirect) begin
            pc <= {redirect_pc[31:2], 2'b00};
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    // One credit out per issue, one back per consumed or discarded response
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(FETCH_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(credit_return) + CREDIT_W'(drop)
                       - CREDIT_W'(issue);
        end
    end

    // Halt after an unmapped fetch until software redirects
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            fault_stop <= 1'b0;
        end else if (issue && pc_src == SRC_NONE) begin
            fault_stop <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Source requests and attribute push
    assign lmem_req.new_request = issue & (pc_src == SRC_LMEM);
    assign lmem_req.addr        = pc;
    assign bus_req.new_request  = issue & (pc_src == SRC_BUS);
    assign bus_req.addr         = pc;

    assign attr_push     = issue;
    assign attr_in.pc    = pc;
    assign attr_in.src   = pc_src;
    assign attr_in.fault = (pc_src == SRC_NONE);

    credit_bound_a: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(FETCH_CREDITS))
        else $error("Credit count above FETCH_CREDITS");

endmodule

/* source/fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the instruction fetch unit
// Address map of the local memory and the bus range, reset vector,
// credit count, in-flight depth, and the packed structs exchanged
// between the issue controller, the sources and the response logic
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // Address map
    localparam logic [31:0] RESET_VEC  = 32'h0000_0000;
    localparam logic [31:0] LMEM_BASE  = 32'h0000_0000;
    localparam int          LMEM_WORDS = 32;
    localparam int          LMEM_AW    = $clog2(LMEM_WORDS);
    localparam logic [31:0] BUS_BASE   = 32'h8000_0000;
    localparam logic [31:0] BUS_MASK   = 32'hFFFF_0000;

    // Flow control and tracking depth
    localparam int FETCH_CREDITS = 4;
    localparam int CREDIT_W      = $clog2(FETCH_CREDITS + 1);
    localparam int MAX_INFLIGHT  = 2;
    localparam int INFLIGHT_W    = $clog2(MAX_INFLIGHT + 1);

    typedef enum logic [1:0] {
        SRC_LMEM = 2'd0,
        SRC_BUS  = 2'd1,
        SRC_NONE = 2'd2
    } src_id_t;

    typedef struct packed {
        logic [31:0] pc;
        src_id_t     src;
        logic        fault;
    } fetch_attr_t;

    typedef struct packed {
        logic        new_request;
        logic [31:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic        ready;
        logic        data_valid;
        logic [31:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        fault;
    } fetch_out_t;

    // External bus
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] data;
    } bus_rsp_t;

endpackage

/* source/fetch_response.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch response logic
// Selects data of the head entry's source, completes entries in order,
// discards stale responses after a redirect and forms the output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_response import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect,
    input  logic        attr_push,
    input  logic        head_valid,
    input  fetch_attr_t head,
    input  fetch_rsp_t  lmem_rsp,
    input  fetch_rsp_t  bus_rsp,
    output logic        pop,
    output logic        drop,
    output fetch_out_t  fetch_out
);

    logic [INFLIGHT_W-1:0] inflight;
    logic [INFLIGHT_W-1:0] inflight_next;
    logic [INFLIGHT_W-1:0] flush_count;
    logic [31:0]           sel_data;
    logic                  sel_valid;
    logic                  complete;
    logic                  flushing;

    // Source select for the head entry
    assign sel_data  = (head.src == SRC_BUS) ? bus_rsp.data : lmem_rsp.data;
    assign sel_valid = (head.src == SRC_BUS) ? bus_rsp.data_valid : lmem_rsp.data_valid;

    // Faulting entries need no source response
    assign complete = head_valid & (head.fault | sel_valid);
    assign flushing = (flush_count != '0);

    assign pop  = complete;
    assign drop = complete & flushing;

    ////////////////////////////////////////////////////////////////////////////
    // In-flight and flush tracking
    assign inflight_next = inflight + INFLIGHT_W'(attr_push) - INFLIGHT_W'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight    <= '0;
            flush_count <= '0;
        end else begin
            inflight <= inflight_next;
            if (redirect) begin
                flush_count <= inflight_next;
            end else if (complete && flushing) begin
                flush_count <= flush_count - 1'b1;
            end
        end
    end

    assign fetch_out.valid = complete & ~flushing;
    assign fetch_out.pc    = head.pc;
    assign fetch_out.instr = head.fault ? 32'h0 : sel_data;
    assign fetch_out.fault = head.fault;

    // A response must belong to the entry at the head of the FIFO
    lmem_in_order_a: assert property (@(posedge clk) disable iff (rst)
        lmem_rsp.data_valid |-> (head_valid && head.src == SRC_LMEM))
        else $error("Local memory data_valid without matching head");
    bus_in_order_a: assert property (@(posedge clk) disable iff (rst)
        bus_rsp.data_valid |-> (head_valid && head.src == SRC_BUS))
        else $error("Bus data_valid without matching head");

endmodule

/* source/fetch_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction fetch unit top level
// Connects the issue controller, attribute FIFO, response logic,
// local instruction memory and external bus master
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        credit_return,
    output fetch_out_t  fetch_out,
    output bus_req_t    bus_out,
    input  bus_rsp_t    bus_in
);

    fetch_req_t  lmem_req;
    fetch_req_t  bus_req;
    fetch_rsp_t  lmem_rsp;
    fetch_rsp_t  bus_rsp;
    logic        attr_push;
    fetch_attr_t attr_in;
    logic        fifo_full;
    logic        head_valid;
    fetch_attr_t head;
    logic        pop;
    logic        drop;

    fetch_issue_ctrl issue_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .credit_return (credit_return),
        .drop          (drop),
        .fifo_full     (fifo_full),
        .lmem_rsp      (lmem_rsp),
        .bus_rsp       (bus_rsp),
        .lmem_req      (lmem_req),
        .bus_req       (bus_req),
        .attr_push     (attr_push),
        .attr_in       (attr_in)
    );

    fetch_attr_fifo attr_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (attr_push),
        .data_in  (attr_in),
        .pop      (pop),
        .full     (fifo_full),
        .valid    (head_valid),
        .data_out (head)
    );

    fetch_response response_i (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .attr_push  (attr_push),
        .head_valid (head_valid),
        .head       (head),
        .lmem_rsp   (lmem_rsp),
        .bus_rsp    (bus_rsp),
        .pop        (pop),
        .drop       (drop),
        .fetch_out  (fetch_out)
    );

    // Fetch sources
    ilocal_mem lmem_i (
        .clk (clk),
        .rst (rst),
        .req (lmem_req),
        .rsp (lmem_rsp)
    );

    ibus_master bus_i (
        .clk     (clk),
        .rst     (rst),
        .req     (bus_req),
        .bus_in  (bus_in),
        .rsp     (bus_rsp),
        .bus_out (bus_out)
    );

endmodule

/* source/ibus_master.sv */
////////////////////////////////////////////////////////////////////////////
// External bus fetch source
// Idle/busy FSM holding a single outstanding request until ack
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ibus_master import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_req_t req,
    input  bus_rsp_t   bus_in,
    output fetch_rsp_t rsp,
    output bus_req_t   bus_out
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } bus_state_t;

    bus_state_t  state;
    logic [31:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req.new_request) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (bus_in.ack) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Address held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && req.new_request) begin
            addr_q <= req.addr;
        end
    end

    assign bus_out.req  = (state == BUSY);
    assign bus_out.addr = addr_q;

    assign rsp.ready      = (state == IDLE);
    assign rsp.data_valid = (state == BUSY) & bus_in.ack;
    assign rsp.data       = bus_in.data;

    // A request arriving in BUSY would be lost
    req_when_idle_a: assert property (@(posedge clk) disable iff (rst)
        req.new_request |-> (state == IDLE))
        else $error("Bus fetch request while a transfer is outstanding");

endmodule

/* source/ilocal_mem.hex */
// One 32-bit instruction word per line, word addresses 0 to 31 (addi x1, x0, index)
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00A00093
00B00093
00C00093
00D00093
00E00093
00F00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01A00093
01B00093
01C00093
01D00093
01E00093
01F00093

/* source/ilocal_mem.sv */
////////////////////////////////////////////////////////////////////////////
// Local instruction memory source
// 32-word array with registered read, one cycle of latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ilocal_mem import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_req_t req,
    output fetch_rsp_t rsp
);

    logic [31:0]        mem [LMEM_WORDS];
    logic [LMEM_AW-1:0] word_idx;
    logic [31:0]        rd_data;
    logic               rd_valid;

    initial begin
        $readmemh("source/ilocal_mem.hex", mem);
    end

    assign word_idx = req.addr[LMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (req.new_request) begin
            rd_data <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.new_request;
        end
    end

    // Pipelined, accepts a request every cycle
    assign rsp.ready      = 1'b1;
    assign rsp.data_valid = rd_valid;
    assign rsp.data       = rd_data;

endmodule

/* tb/fetch_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the instruction fetch unit
// Clock and reset, LFSR random source, bus responder with random ack
// delay, credit-returning consumer, reference model and the tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        credit_return = 1'b0;
    fetch_out_t  fetch_out;
    bus_req_t    bus_out;
    bus_rsp_t    bus_in = '0;

    logic [31:0] lmem_model [LMEM_WORDS];
    logic [31:0] lfsr_state = 32'hcfd9_a645;
    logic [31:0] exp_pc;
    logic [31:0] target;
    logic        fault_seen;
    logic        hold_credits;
    logic        after_ack;
    int          credit_due [$];
    int          withheld = 0;
    int          cycle = 0;
    int          bus_wait = -1;
    int          delivered = 0;
    int          faults = 0;
    int          snapshot;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          tests_failed = 0;
    int          test_start_errors = 0;

    fetch_unit dut_i (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .credit_return (credit_return),
        .fetch_out     (fetch_out),
        .bus_out       (bus_out),
        .bus_in        (bus_in)
    );

    initial begin
        $readmemh("source/ilocal_mem.hex", lmem_model);
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Fault flag and instruction expected at a PC by the address map
    function automatic logic [32:0] expected_fetch(input logic [31:0] pc);
        if (pc < 32'(LMEM_WORDS * 4)) begin
            return {1'b0, lmem_model[pc[LMEM_AW+1:2]]};
        end else if (pc[31:16] == 16'h8000) begin
            return {1'b0, pc ^ 32'h5a5a_0000};
        end
        return {1'b1, 32'h0};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %0t: %s mismatch, got %h, expected %h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    // Wait on falling edges until the delivery or fault counter advances by count
    task automatic wait_for_count(input bit on_faults, input int count, input int limit,
                                  input string what);
        int goal;
        int waited;
        @(negedge clk);
        goal   = (on_faults ? faults : delivered) + count;
        waited = 0;
        while ((on_faults ? faults : delivered) < goal && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if ((on_faults ? faults : delivered) < goal) begin
            $display("Timeout after %0d cycles while waiting for %s", limit, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("Test %0d, %s: passed", tests, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: failed with %0d errors",
                     tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus responder and consumer

    // The cycle after an ack must have req low
    always @(posedge clk) begin
        if (rst) begin
            bus_in    <= '0;
            bus_wait  = -1;
            after_ack = 1'b0;
        end else if (bus_in.ack) begin
            bus_in.ack <= 1'b0;
            after_ack  = 1'b1;
        end else begin
            if (after_ack) begin
                check_equal("bus req after ack", {31'b0, bus_out.req}, 32'h0);
                after_ack = 1'b0;
            end
            if (bus_out.req) begin
                if (bus_wait < 0) begin
                    bus_wait = int'(rand_bits(3) % 6);
                end
                if (bus_wait == 0) begin
                    bus_in.ack  <= 1'b1;
                    bus_in.data <= bus_out.addr ^ 32'h5a5a_0000;
                    bus_wait = -1;
                end else begin
                    bus_wait--;
                end
            end
        end
    end

    // One credit per delivery 0 to 3 cycles later unless withheld
    always @(posedge clk) begin
        if (rst) begin
            credit_return <= 1'b0;
        end else begin
            cycle++;
            if (fetch_out.valid && hold_credits) begin
                withheld++;
            end else if (fetch_out.valid) begin
                credit_due.push_back(cycle + int'(rand_bits(2)));
            end
            if (!hold_credits && withheld > 0) begin
                credit_due.push_back(cycle);
                withheld--;
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                credit_return <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    // Delivery is checked before a redirect seen in the same cycle
    always @(posedge clk) begin
        logic [32:0] exp;
        if (rst) begin
            exp_pc     = RESET_VEC;
            fault_seen = 1'b0;
        end else begin
            if (fetch_out.valid) begin
                delivered++;
                exp = expected_fetch(exp_pc);
                check_equal("delivery after fault", {31'b0, fault_seen}, 32'h0);
                check_equal("pc", fetch_out.pc, exp_pc);
                check_equal("fault", {31'b0, fetch_out.fault}, {31'b0, exp[32]});
                if (exp[32]) begin
                    fault_seen = 1'b1;
                    faults++;
                end else begin
                    check_equal("instr", fetch_out.instr, exp[31:0]);
                end
                exp_pc = exp_pc + 32'd4;
            end
            if (redirect) begin
                exp_pc     = {redirect_pc[31:2], 2'b00};
                fault_seen = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    initial begin
        rst          = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        hold_credits = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        wait_for_count(1'b0, 32, 500, "local words from the reset vector");
        end_test("local fetch from reset vector");

        redirect_to(32'h8000_0100);
        wait_for_count(1'b0, 16, 600, "bus fetches");
        end_test("bus fetch with random ack delay");

        for (int i = 0; i < 24; i++) begin
            repeat (rand_bits(3)) @(posedge clk);
            if (rand_bits(1) == 32'h1) begin
                target = 32'h8000_0000 | (rand_bits(14) << 2);
            end else begin
                target = rand_bits(5) << 2;
            end
            redirect_to(target);
        end
        wait_for_count(1'b0, 1, 200, "a delivery after the last redirect");
        end_test("random redirects in flight");

        redirect_to(32'h4000_0000);
        wait_for_count(1'b1, 1, 200, "the faulting delivery");
        snapshot = delivered;
        repeat (50) @(negedge clk);
        check_equal("deliveries while stopped", delivered, snapshot);
        redirect_to(32'h0000_0010);
        wait_for_count(1'b0, 4, 200, "fetch after the fault");
        end_test("fault stop until redirect");

        // Credits for the new stream only are held back
        redirect_to(32'h0000_0040);
        hold_credits <= 1'b1;
        @(negedge clk);
        snapshot = delivered;
        repeat (60) @(negedge clk);
        check_equal("deliveries without credits", delivered - snapshot, FETCH_CREDITS);
        @(posedge clk);
        hold_credits <= 1'b0;
        wait_for_count(1'b0, 8, 300, "delivery after credits return");
        end_test("credit back-pressure");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
